// File: filelist.f
source/replica_pkg.sv
source/distance_ram.sv
source/random.sv
source/sub_node.sv
source/replica_exchange.sv
source/node.sv
tests/node_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the node testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module node_tb --Mdir obj_dir \
    -f filelist.f

output="$(./obj_dir/Vnode_tb 2>&1 || true)"
echo "$output"

if grep -qx "TEST PASS" <<< "$output"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: source/distance_ram.sv
module distance_ram
    import replica_pkg::*;
(
    input  logic                  clk,

    input  logic                  write,            // host load
    input  logic [dis_addr_w-1:0] waddr,
    input  distance_data_t        wdata,

    input  logic [dis_addr_w-1:0] or_addr,
    input  logic [dis_addr_w-1:0] tw_addr,
    output distance_data_t        or_data,
    output distance_data_t        tw_data
);

distance_data_t        ram [0:dis_entries-1];
logic [dis_addr_w-1:0] or_port_addr;

// host write borrows the or-opt port
assign or_port_addr = write ? waddr : or_addr;

always_ff @(posedge clk) begin
    if (write) begin
        ram[or_port_addr] <= wdata;
    end
    or_data <= ram[or_port_addr];                   // old data on collision
end

always_ff @(posedge clk) begin
    tw_data <= ram[tw_addr];
end

a_waddr_range: assert property (@(posedge clk) write |-> waddr < dis_entries)
    else $error("distance write address %0d out of table", waddr);

endmodule

// File: source/node.sv
module node
    import replica_pkg::*;
#(
    parameter logic [15:0] or_thresh = 16'd0,
    parameter logic [15:0] tw_thresh = 16'd0
)
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  tp_dis_write,     // distance table load
    input  logic [dis_addr_w-1:0] tp_dis_waddr,
    input  distance_data_t        tp_dis_wdata,

    input  logic                  random_init,
    input  logic                  random_read,
    input  logic [63:0]           random_seed_w,
    output logic [63:0]           random_seed_r,
    output logic                  random_ready,

    input  logic                  or_total_init,
    input  logic                  tw_total_init,
    input  total_data_t           total_init_value,

    input  logic                  opt_run,
    input  logic                  or_opt_en,
    input  logic                  tw_opt_en,
    input  distance_command_t     or_distance_com,
    input  distance_command_t     tw_distance_com,

    input  logic                  exchange_run,

    output logic                  or_done,
    output logic                  tw_done,
    output logic                  or_accepted,
    output logic                  tw_accepted,
    output total_data_t           or_total,
    output total_data_t           tw_total,
    output total_data_t           minimum_distance,
    output logic                  exchanged
);

logic [dis_addr_w-1:0] or_distance_addr;
logic [dis_addr_w-1:0] tw_distance_addr;
distance_data_t        or_distance_data;
distance_data_t        tw_distance_data;
logic [15:0]           or_rand;
logic [15:0]           tw_rand;
logic                  or_busy;
logic                  tw_busy;
total_data_t           swap_or_total;
total_data_t           swap_tw_total;
logic                  swap_load;

distance_ram distance_ram (
    .clk     ( clk              ),
    .write   ( tp_dis_write     ),
    .waddr   ( tp_dis_waddr     ),
    .wdata   ( tp_dis_wdata     ),
    .or_addr ( or_distance_addr ),
    .tw_addr ( tw_distance_addr ),
    .or_data ( or_distance_data ),
    .tw_data ( tw_distance_data )
);

random random (
    .clk     ( clk           ),
    .rst_n   ( rst_n         ),
    .init    ( random_init   ),
    .read    ( random_read   ),
    .run     ( opt_run       ),
    .w_seed  ( random_seed_w ),
    .r_seed  ( random_seed_r ),
    .ready   ( random_ready  ),
    .or_rand ( or_rand       ),
    .tw_rand ( tw_rand       )
);

sub_node #(.two_opt_node(0), .temp_thresh(or_thresh)) or_node (
    .clk           ( clk              ),
    .rst_n         ( rst_n            ),
    .opt_run       ( opt_run          ),
    .opt_en        ( or_opt_en        ),
    .distance_com  ( or_distance_com  ),
    .rand_val      ( or_rand          ),
    .distance_addr ( or_distance_addr ),
    .distance_data ( or_distance_data ),
    .total_init    ( or_total_init    ),
    .init_value    ( total_init_value ),
    .swap_load     ( swap_load        ),
    .swap_value    ( swap_or_total    ),
    .total         ( or_total         ),
    .busy          ( or_busy          ),
    .done          ( or_done          ),
    .accepted      ( or_accepted      )
);

sub_node #(.two_opt_node(1), .temp_thresh(tw_thresh)) two_node (
    .clk           ( clk              ),
    .rst_n         ( rst_n            ),
    .opt_run       ( opt_run          ),
    .opt_en        ( tw_opt_en        ),
    .distance_com  ( tw_distance_com  ),
    .rand_val      ( tw_rand          ),
    .distance_addr ( tw_distance_addr ),
    .distance_data ( tw_distance_data ),
    .total_init    ( tw_total_init    ),
    .init_value    ( total_init_value ),
    .swap_load     ( swap_load        ),
    .swap_value    ( swap_tw_total    ),
    .total         ( tw_total         ),
    .busy          ( tw_busy          ),
    .done          ( tw_done          ),
    .accepted      ( tw_accepted      )
);

replica_exchange exchange (
    .clk              ( clk              ),
    .rst_n            ( rst_n            ),
    .exchange_run     ( exchange_run     ),
    .or_total         ( or_total         ),
    .tw_total         ( tw_total         ),
    .swap_or_total    ( swap_or_total    ),
    .swap_tw_total    ( swap_tw_total    ),
    .swap_load        ( swap_load        ),
    .exchanged        ( exchanged        ),
    .minimum_distance ( minimum_distance )
);

// exchange only between moves
a_exchange_idle: assert property (
    @(posedge clk) disable iff (!rst_n) exchange_run |-> !or_busy && !tw_busy)
    else $error("exchange_run while a replica is busy");

endmodule

// File: source/random.sv
module random
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        init,                       // load seed
    input  logic        read,                       // capture state
    input  logic        run,                        // one step per opt_run
    input  logic [63:0] w_seed,
    output logic [63:0] r_seed,
    output logic        ready,

    output logic [15:0] or_rand,
    output logic [15:0] tw_rand
);

logic [63:0] state;
logic [63:0] sh_a;
logic [63:0] sh_b;
logic [63:0] sh_c;

// xorshift64, shifts 13 / 7 / 17
always_comb begin
    sh_a = state ^ (state << 13);
    sh_b = sh_a ^ (sh_a >> 7);
    sh_c = sh_b ^ (sh_b << 17);
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state <= '0;
        ready <= 1'b0;
    end else begin
        if (init) begin
            state <= w_seed;
            ready <= 1'b1;                          // stays set
        end else if (run) begin
            state <= sh_c;
        end
    end
end

always_ff @(posedge clk) begin
    if (read) begin
        r_seed <= state;
    end
end

// fresh draws for each replica
assign or_rand = state[15:0];
assign tw_rand = state[31:16];

// a zero state would lock the generator
a_state_live: assert property (@(posedge clk) disable iff (!rst_n) ready |-> state != '0)
    else $error("random state is zero");

endmodule

// File: source/replica_exchange.sv
module replica_exchange
    import replica_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        exchange_run,
    input  total_data_t or_total,
    input  total_data_t tw_total,

    output total_data_t swap_or_total,
    output total_data_t swap_tw_total,
    output logic        swap_load,
    output logic        exchanged,
    output total_data_t minimum_distance
);

logic or_shorter;

assign or_shorter = or_total < tw_total;

// hotter replica found the shorter tour, hand it to the cooler one
assign swap_load     = exchange_run && or_shorter;
assign swap_or_total = tw_total;
assign swap_tw_total = or_total;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        exchanged        <= 1'b0;
        minimum_distance <= '0;
    end else begin
        exchanged        <= swap_load;
        minimum_distance <= or_shorter ? or_total : tw_total;
    end
end

// both replicas must have taken the swapped totals
a_swap_done: assert property (
    @(posedge clk) disable iff (!rst_n) exchanged |-> tw_total < or_total)
    else $error("exchange did not leave the shorter tour in the 2-opt replica");

endmodule

// File: source/replica_pkg.sv
package replica_pkg;

    // problem size
    localparam int city_num   = 16;
    localparam int city_log   = 4;
    localparam int dis_addr_w = 8;

    // lower triangle including the diagonal
    localparam int dis_entries = city_num * (city_num + 1) / 2;

    typedef logic [15:0] distance_data_t;           // one city-to-city distance

    typedef logic signed [23:0] total_data_t;       // tour length or move delta

    // 2-opt: remove a-b, c-d and add a-c, b-d
    // or-opt: move b from between a and c to between d and e
    typedef struct packed {
        logic [city_log-1:0] a;
        logic [city_log-1:0] b;
        logic [city_log-1:0] c;
        logic [city_log-1:0] d;
        logic [city_log-1:0] e;
        logic [city_log-1:0] f;                     // spare
    } distance_command_t;

    // Triangular table address. The pair is ordered first so that the larger
    // index i selects the row, then the entry is i*(i+1)/2 + j for i >= j.
    function automatic logic [dis_addr_w-1:0] tri_addr(
        input logic [city_log-1:0] x,
        input logic [city_log-1:0] y
    );
        logic [dis_addr_w-1:0] hi;
        logic [dis_addr_w-1:0] lo;
        if (x >= y) begin
            hi = dis_addr_w'(x);
            lo = dis_addr_w'(y);
        end else begin
            hi = dis_addr_w'(y);
            lo = dis_addr_w'(x);
        end
        return hi * (hi + 1'b1) / 2 + lo;
    endfunction

endpackage

// File: source/sub_node.sv
module sub_node
    import replica_pkg::*;
#(
    parameter int          two_opt_node = 0,
    parameter logic [15:0] temp_thresh  = 16'd0
)
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  opt_run,          // step strobe
    input  logic                  opt_en,
    input  distance_command_t     distance_com,
    input  logic [15:0]           rand_val,

    output logic [dis_addr_w-1:0] distance_addr,    // data returns next cycle
    input  distance_data_t        distance_data,

    input  logic                  total_init,
    input  total_data_t           init_value,
    input  logic                  swap_load,        // from exchange
    input  total_data_t           swap_value,
    output total_data_t           total,

    output logic                  busy,
    output logic                  done,
    output logic                  accepted
);

localparam int terms = (two_opt_node != 0) ? 4 : 6;

distance_command_t     com;
logic [2:0]            step;
logic                  issuing;
logic                  rd_valid;
logic                  rd_sub;
logic                  rd_last;
logic [2*city_log:0]   term;
logic                  term_sub;
logic [city_log-1:0]   city_x;
logic [city_log-1:0]   city_y;
total_data_t           dist_ext;
total_data_t           delta;
total_data_t           delta_next;
logic                  start;
logic                  accept;

assign start = opt_run && opt_en && !busy;

// {subtract, city, city} for each read of the move
always_comb begin
    term = '0;
    if (two_opt_node != 0) begin
        case (step)
            3'd0:    term = {1'b0, com.a, com.c};
            3'd1:    term = {1'b0, com.b, com.d};
            3'd2:    term = {1'b1, com.a, com.b};
            3'd3:    term = {1'b1, com.c, com.d};
            default: term = '0;
        endcase
    end else begin
        case (step)
            3'd0:    term = {1'b0, com.a, com.c};
            3'd1:    term = {1'b0, com.d, com.b};
            3'd2:    term = {1'b0, com.b, com.e};
            3'd3:    term = {1'b1, com.a, com.b};
            3'd4:    term = {1'b1, com.b, com.c};
            3'd5:    term = {1'b1, com.d, com.e};
            default: term = '0;
        endcase
    end
end

assign {term_sub, city_x, city_y} = term;
assign distance_addr = tri_addr(city_x, city_y);

assign dist_ext   = total_data_t'(distance_data);
assign delta_next = rd_sub ? delta - dist_ext : delta + dist_ext;

// threshold stands in for exp(-delta/T)
assign accept = (delta_next < 0) || (rand_val < temp_thresh);

always_ff @(posedge clk) begin
    if (start) begin
        com <= distance_com;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        busy     <= 1'b0;
        issuing  <= 1'b0;
        step     <= '0;
        rd_valid <= 1'b0;
        rd_sub   <= 1'b0;
        rd_last  <= 1'b0;
        delta    <= '0;
        done     <= 1'b0;
        accepted <= 1'b0;
        total    <= '0;
    end else begin
        done     <= 1'b0;
        rd_valid <= issuing;                        // ram latency
        rd_sub   <= term_sub;
        rd_last  <= issuing && (step == 3'(terms - 1));
        if (start) begin
            busy    <= 1'b1;
            issuing <= 1'b1;
            step    <= '0;
            delta   <= '0;
        end else if (issuing) begin
            step <= step + 3'd1;
            if (step == 3'(terms - 1)) begin
                issuing <= 1'b0;
            end
        end
        if (rd_valid) begin
            delta <= delta_next;
            if (rd_last) begin
                busy     <= 1'b0;
                done     <= 1'b1;
                accepted <= accept;
            end
        end
        if (total_init) begin
            total <= init_value;
        end else if (swap_load) begin
            total <= swap_value;
        end else if (rd_valid && rd_last && accept) begin
            total <= total + delta_next;            // lands with done
        end
    end
end

a_run_idle: assert property (@(posedge clk) disable iff (!rst_n) opt_run |-> !busy)
    else $error("opt_run while replica busy");

a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done held for two cycles");

endmodule

// File: tests/node_tb.sv
module node_tb
    import replica_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

logic                  clk = 1'b0;
logic                  rst_n;
logic                  tp_dis_write;
logic [dis_addr_w-1:0] tp_dis_waddr;
distance_data_t        tp_dis_wdata;
logic                  random_init;
logic                  random_read;
logic [63:0]           random_seed_w;
logic [63:0]           random_seed_r;
logic                  random_ready;
logic                  or_total_init;
logic                  tw_total_init;
total_data_t           total_init_value;
logic                  opt_run;
logic                  or_opt_en;
logic                  tw_opt_en;
distance_command_t     or_distance_com;
distance_command_t     tw_distance_com;
logic                  exchange_run;
logic                  or_done;
logic                  tw_done;
logic                  or_accepted;
logic                  tw_accepted;
total_data_t           or_total;
total_data_t           tw_total;
total_data_t           minimum_distance;
logic                  exchanged;

int             seed = 53;
distance_data_t dist_copy [0:dis_entries-1];    // host side copy of the table
logic [63:0]    model_state;
total_data_t    or_model = '0;                  // expected totals between moves
total_data_t    tw_model = '0;
total_data_t    or_exp_delta = '0;
total_data_t    tw_exp_delta = '0;
total_data_t    or_base = '0;
total_data_t    tw_base = '0;

always #4 clk = ~clk;

node #(.or_thresh(16'd0), .tw_thresh(16'd0)) dut0 (.*);

task automatic report_failure(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1, "check failed");
endtask

task automatic report_timeout(input string what);
    $display("timeout: no %s within 100 cycles", what);
    $display("TEST FAIL");
    $fatal(1, "wait expired");
endtask

function automatic logic [63:0] xorshift_step(input logic [63:0] s);
    logic [63:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
endfunction

// lower triangle lookup, larger index picks the row
function automatic int pair_dist(input int x, input int y);
    int hi;
    int lo;
    hi = (x > y) ? x : y;
    lo = (x > y) ? y : x;
    return int'(dist_copy[hi * (hi + 1) / 2 + lo]);
endfunction

function automatic total_data_t two_opt_delta(input distance_command_t c);
    int d;
    d = pair_dist(c.a, c.c) + pair_dist(c.b, c.d) - pair_dist(c.a, c.b) - pair_dist(c.c, c.d);
    return total_data_t'(d);
endfunction

function automatic total_data_t or_opt_delta(input distance_command_t c);
    int d;
    d = pair_dist(c.a, c.c) + pair_dist(c.d, c.b) + pair_dist(c.b, c.e);
    d = d - pair_dist(c.a, c.b) - pair_dist(c.b, c.c) - pair_dist(c.d, c.e);
    return total_data_t'(d);
endfunction

function automatic distance_command_t make_command(input int a, input int b, input int c,
                                                   input int d, input int e);
    distance_command_t cmd;
    cmd.a = city_log'(a);
    cmd.b = city_log'(b);
    cmd.c = city_log'(c);
    cmd.d = city_log'(d);
    cmd.e = city_log'(e);
    cmd.f = '0;
    return cmd;
endfunction

function automatic distance_command_t random_command();
    int v [0:4];
    for (int i = 0; i < 5; i++) begin
        v[i] = int'($unsigned($random(seed)) % city_num);
    end
    return make_command(v[0], v[1], v[2], v[3], v[4]);
endfunction

// generator state as the host expects it
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        model_state <= '0;
    end else if (random_init) begin
        model_state <= random_seed_w;
    end else if (opt_run) begin
        model_state <= xorshift_step(model_state);
    end
end

a_ready_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $past(random_init) |-> random_ready)
    else report_failure("random_ready low one cycle after random_init");
a_ready_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(random_ready) |-> $past(random_init))
    else report_failure("random_ready rose without random_init");
a_seed_read: assert property (@(posedge clk) disable iff (!rst_n)
    $past(random_read) |-> random_seed_r == $past(model_state))
    else report_failure("random_seed_r differs from xorshift64 model");
a_tw_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(opt_run && tw_opt_en, 6) |-> tw_done)
    else report_failure("tw_done missing 6 cycles after opt_run");
a_tw_cause: assert property (@(posedge clk) disable iff (!rst_n)
    tw_done |-> $past(opt_run && tw_opt_en, 6))
    else report_failure("tw_done without enabled opt_run 6 cycles before");
a_tw_result: assert property (@(posedge clk) disable iff (!rst_n)
    tw_done |-> tw_accepted == (tw_exp_delta < 0) &&
        tw_total == ((tw_exp_delta < 0) ? tw_base + tw_exp_delta : tw_base))
    else report_failure("2-opt acceptance or tw_total wrong");
a_or_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(opt_run && or_opt_en, 8) |-> or_done)
    else report_failure("or_done missing 8 cycles after opt_run");
a_or_cause: assert property (@(posedge clk) disable iff (!rst_n)
    or_done |-> $past(opt_run && or_opt_en, 8))
    else report_failure("or_done without enabled opt_run 8 cycles before");
a_or_result: assert property (@(posedge clk) disable iff (!rst_n)
    or_done |-> or_accepted == (or_exp_delta < 0) &&
        or_total == ((or_exp_delta < 0) ? or_base + or_exp_delta : or_base))
    else report_failure("or-opt acceptance or or_total wrong");
a_or_idle: assert property (@(posedge clk) disable iff (!rst_n)
    $past(opt_run && !or_opt_en, 8) |-> or_total == $past(or_total, 8))
    else report_failure("disabled or-opt replica changed its total");
a_tw_idle: assert property (@(posedge clk) disable iff (!rst_n)
    $past(opt_run && !tw_opt_en, 6) |-> tw_total == $past(tw_total, 6))
    else report_failure("disabled 2-opt replica changed its total");
a_or_init: assert property (@(posedge clk) disable iff (!rst_n)
    $past(or_total_init) |-> or_total == $past(total_init_value))
    else report_failure("or_total not loaded by or_total_init");
a_tw_init: assert property (@(posedge clk) disable iff (!rst_n)
    $past(tw_total_init) |-> tw_total == $past(total_init_value))
    else report_failure("tw_total not loaded by tw_total_init");
a_swap: assert property (@(posedge clk) disable iff (!rst_n)
    $past(exchange_run && or_total < tw_total) |->
        exchanged && or_total == $past(tw_total) && tw_total == $past(or_total))
    else report_failure("exchange with or_total below tw_total did not swap");
a_no_swap: assert property (@(posedge clk) disable iff (!rst_n)
    $past(exchange_run && or_total >= tw_total) |->
        !exchanged && or_total == $past(or_total) && tw_total == $past(tw_total))
    else report_failure("exchange swapped although or_total was not smaller");
a_minimum: assert property (@(posedge clk) disable iff (!rst_n)
    minimum_distance == (($signed($past(or_total)) < $signed($past(tw_total))) ?
        $past(or_total) : $past(tw_total)))
    else report_failure("minimum_distance is not the smaller total");

task automatic load_distances();
    int order [0:dis_entries-1];
    int j;
    int tmp;
    for (int k = 0; k < dis_entries; k++) begin
        order[k] = k;
    end
    for (int k = dis_entries - 1; k > 0; k--) begin    // shuffle write order
        j = int'($unsigned($random(seed)) % (k + 1));
        tmp = order[k];
        order[k] = order[j];
        order[j] = tmp;
    end
    for (int k = 0; k < dis_entries; k++) begin
        dist_copy[order[k]] = distance_data_t'(1 + $unsigned($random(seed)) % 4000);
        tp_dis_write <= 1'b1;
        tp_dis_waddr <= dis_addr_w'(order[k]);
        tp_dis_wdata <= dist_copy[order[k]];
        @(posedge clk);
    end
    tp_dis_write <= 1'b0;
    @(posedge clk);
endtask

task automatic seed_random();
    int cycles;
    cycles = 0;
    random_seed_w <= {$random(seed), $random(seed)} | 64'd1;   // never zero
    random_init   <= 1'b1;
    @(posedge clk);
    random_init <= 1'b0;
    while (!random_ready) begin
        @(negedge clk);
        cycles++;
        if (cycles > 100) report_timeout("random_ready");
    end
    @(posedge clk);
endtask

task automatic read_seed();
    random_read <= 1'b1;
    @(posedge clk);
    random_read <= 1'b0;
    @(posedge clk);
endtask

task automatic init_total(input logic tw_sel, input total_data_t value);
    total_init_value <= value;
    or_total_init    <= !tw_sel;
    tw_total_init    <= tw_sel;
    @(posedge clk);
    or_total_init <= 1'b0;
    tw_total_init <= 1'b0;
    if (tw_sel) tw_model = value;
    else or_model = value;
    @(posedge clk);
endtask

task automatic run_step(input logic or_en, input logic tw_en,
                        input distance_command_t or_cmd, input distance_command_t tw_cmd);
    int cycles;
    logic or_seen;
    logic tw_seen;
    or_exp_delta = or_opt_delta(or_cmd);
    tw_exp_delta = two_opt_delta(tw_cmd);
    or_base = or_model;
    tw_base = tw_model;
    or_seen = !or_en;
    tw_seen = !tw_en;
    cycles  = 0;
    opt_run         <= 1'b1;
    or_opt_en       <= or_en;
    tw_opt_en       <= tw_en;
    or_distance_com <= or_cmd;
    tw_distance_com <= tw_cmd;
    @(posedge clk);
    opt_run <= 1'b0;
    while (!(or_seen && tw_seen)) begin
        @(negedge clk);
        if (or_done) or_seen = 1'b1;
        if (tw_done) tw_seen = 1'b1;
        cycles++;
        if (cycles > 100) report_timeout("done pulse after opt_run");
    end
    if (or_en && or_exp_delta < 0) or_model = or_model + or_exp_delta;
    if (tw_en && tw_exp_delta < 0) tw_model = tw_model + tw_exp_delta;
    repeat (8) @(posedge clk);                  // let idle-total checks mature
endtask

task automatic run_exchange();
    int          cycles;
    logic        expect_swap;
    total_data_t tmp;
    cycles = 0;
    expect_swap = or_model < tw_model;
    exchange_run <= 1'b1;
    @(posedge clk);
    exchange_run <= 1'b0;
    if (expect_swap) begin
        while (!exchanged) begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) report_timeout("exchanged pulse");
        end
        tmp = or_model;
        or_model = tw_model;
        tw_model = tmp;
    end
    repeat (3) @(posedge clk);
endtask

initial begin
    logic [1:0] en;
    rst_n            = 1'b0;
    tp_dis_write     = 1'b0;
    tp_dis_waddr     = '0;
    tp_dis_wdata     = '0;
    random_init      = 1'b0;
    random_read      = 1'b0;
    random_seed_w    = '0;
    or_total_init    = 1'b0;
    tw_total_init    = 1'b0;
    total_init_value = '0;
    opt_run          = 1'b0;
    or_opt_en        = 1'b0;
    tw_opt_en        = 1'b0;
    or_distance_com  = '0;
    tw_distance_com  = '0;
    exchange_run     = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    load_distances();
    seed_random();
    read_seed();
    init_total(1'b0, 24'sd50000);
    init_total(1'b1, 24'sd60000);
    run_step(1'b1, 1'b1, make_command(1, 5, 9, 12, 3), make_command(2, 7, 11, 14, 0));
    run_step(1'b1, 1'b1, make_command(5, 5, 2, 9, 9), make_command(3, 3, 8, 8, 0));
    run_step(1'b1, 1'b0, make_command(12, 3, 12, 3, 7), make_command(0, 0, 0, 0, 0));
    run_step(1'b0, 1'b1, make_command(0, 0, 0, 0, 0), make_command(9, 4, 4, 9, 0));
    run_step(1'b1, 1'b1, make_command(14, 2, 6, 2, 14), make_command(15, 0, 0, 15, 0));
    run_step(1'b0, 1'b0, random_command(), random_command());
    read_seed();
    run_exchange();                             // or-opt holds the shorter tour
    run_exchange();                             // second one leaves totals alone
    for (int k = 0; k < 24; k++) begin
        en = 2'($random(seed));
        run_step(en[0], en[1], random_command(), random_command());
        if (k % 4 == 3) begin
            run_exchange();
            read_seed();
        end
    end
    repeat (4) @(posedge clk);
    $display("TEST PASS");
    $finish;
end

endmodule
